// File: list.f
+incdir+hw
hw/div_pkg.sv
hw/div_radix2.sv
hw/div_issue.sv
hw/div_writeback.sv
hw/div_unit_top.sv
verif/div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/div_pkg.sv
      - hw/div_radix2.sv
      - hw/div_issue.sv
      - hw/div_writeback.sv
      - hw/div_unit_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verif/div_unit_tb.sv

// File: verif/div_unit_tb.sv
`include "div_defs.svh"

module div_unit_tb
    import div_pkg::*;
();

    localparam int N_TAGS = 1 << `DIV_TAG_W;
    // Cycles any single wait may take before the run is abandoned.
    localparam int WAIT_LIMIT = 1000;
    localparam word_t MIN_W = word_t'(1) << (`DIV_WIDTH - 1);
    localparam word_t MAX_W = ~MIN_W;

    logic     clk = 1'b0;
    logic     rst;
    logic     req_valid;
    div_req_t req;
    logic     unit_ready;
    logic     rsp_valid;
    div_rsp_t rsp;

    // Scoreboard indexed by tag.
    word_t exp_val [N_TAGS];
    int    exp_edge [N_TAGS];
    bit    lat_chk [N_TAGS];
    bit    pending [N_TAGS];
    tag_t  next_tag = '0;

    int cyc = 0;
    int n_issued = 0;
    int n_returned = 0;
    int n_checks = 0;
    int n_errors = 0;
    // Set once unit_ready is seen low with every lane occupied.
    bit saw_full = 1'b0;

    always #4 clk = ~clk;

    // Edge counter that equals n right after rising edge n.
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    div_unit_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .unit_ready (unit_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    // RISC-V DIV, DIVU, REM and REMU.
    function automatic word_t ref_div(input div_req_t r);
        logic signed [`DIV_WIDTH-1:0] sa;
        logic signed [`DIV_WIDTH-1:0] sb;
        word_t res;
        sa = r.dividend;
        sb = r.divisor;
        if (r.divisor == '0) begin
            // Quotient is all ones and remainder is the dividend.
            res = r.want_rem ? r.dividend : '1;
        end else if (!r.is_signed) begin
            res = r.want_rem ? (r.dividend % r.divisor) : (r.dividend / r.divisor);
        end else if (r.dividend == MIN_W && r.divisor == '1) begin
            // Overflow case.
            res = r.want_rem ? '0 : MIN_W;
        end else begin
            // Truncating divide where the remainder follows the dividend sign.
            res = r.want_rem ? word_t'(sa % sb) : word_t'(sa / sb);
        end
        return res;
    endfunction

    function automatic div_req_t rand_req(input bit with_signed, input bit with_zero);
        div_req_t r;
        int pick;
        pick        = $urandom_range(0, 15);
        r.dividend  = word_t'($urandom);
        r.is_signed = with_signed ? 1'($urandom_range(0, 1)) : 1'b0;
        r.want_rem  = 1'($urandom_range(0, 1));
        r.tag       = '0;
        if (pick < 6) begin
            r.divisor = word_t'($urandom_range(1, 255));
        end else if (pick < 10) begin
            r.divisor = word_t'($urandom) >> $urandom_range(0, `DIV_WIDTH - 1);
        end else begin
            r.divisor = word_t'($urandom);
        end
        // Small negative divisors.
        if (pick >= 3 && pick < 6) begin
            r.divisor = ~r.divisor + word_t'(1);
        end
        if (r.divisor == '0) begin
            r.divisor = word_t'(1);
        end
        if (with_zero && pick == 0) begin
            r.divisor = '0;
        end
        // Tiny dividends give zero quotients.
        if (pick == 15) begin
            r.dividend = word_t'($urandom_range(0, 3));
        end
        return r;
    endfunction

    task automatic check_rsp(input div_rsp_t got, input div_rsp_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("mismatch at %0t: tag %0d result %h, expected tag %0d result %h",
                $time, got.tag, got.result, want.tag, want.result);
        end
    endtask

    task automatic check_ready(input logic got, input logic want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("mismatch at %0t: unit_ready %b, expected %b", $time, got, want);
        end
    endtask

    task automatic abort_run(input string what);
        $display("error at %0t: timeout while %s", $time, what);
        $display("checks %0d, responses %0d of %0d, errors %0d",
            n_checks, n_returned, n_issued, n_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Finds the first tag not in flight from the rotating start.
    function automatic bit find_tag(output tag_t t);
        tag_t c;
        bit   found;
        found = 1'b0;
        t     = next_tag;
        for (int i = 0; i < N_TAGS; i++) begin
            c = tag_t'(int'(next_tag) + i);
            if (!found && !pending[c]) begin
                found = 1'b1;
                t     = c;
            end
        end
        return found;
    endfunction

    // Drives one request once a lane and a tag are surely free.
    task automatic send_req(input div_req_t r, input bit lat);
        int   waited;
        bit   ok;
        tag_t t;
        waited = 0;
        ok     = 1'b0;
        while (!ok) begin
            @(posedge clk);
            ok = find_tag(t);
            ok = ok && (n_issued - n_returned < `DIV_LANES);
            if (ok) begin
                r.tag      = t;
                req_valid <= 1'b1;
                req       <= r;
                pending[t]  = 1'b1;
                exp_val[t]  = ref_div(r);
                lat_chk[t]  = lat;
                // The DUT samples it at the next edge and answers DIV_WIDTH+1 edges later.
                exp_edge[t] = cyc + 2 + `DIV_WIDTH + 1;
                next_tag    = t + tag_t'(1);
                n_issued++;
            end else begin
                req_valid <= 1'b0;
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("waiting for a free lane");
                end
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (n_issued != n_returned) begin
            @(posedge clk);
            req_valid <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("waiting for outstanding results");
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    // Monitor.
    // Outputs are registered and settle before the falling edge.
    always @(negedge clk) begin : monitor
        div_rsp_t want;
        int       lanes_used;
        if (!rst) begin
            if (rsp_valid) begin
                if (!pending[rsp.tag]) begin
                    n_errors++;
                    $display("error at %0t: result with tag %0d that is not in flight",
                        $time, rsp.tag);
                end else begin
                    want.result = exp_val[rsp.tag];
                    want.tag    = rsp.tag;
                    check_rsp(rsp, want);
                    if (lat_chk[rsp.tag] && cyc != exp_edge[rsp.tag]) begin
                        n_errors++;
                        $display("mismatch at %0t: tag %0d arrived at edge %0d, expected %0d",
                            $time, rsp.tag, cyc, exp_edge[rsp.tag]);
                    end
                    pending[rsp.tag] = 1'b0;
                    n_returned++;
                end
            end
            // Lanes held after this edge without the request still on the bus.
            lanes_used = n_issued - int'(req_valid) - n_returned;
            if (lanes_used >= `DIV_LANES && !unit_ready) begin
                saw_full = 1'b1;
            end
            check_ready(unit_ready, lanes_used < `DIV_LANES);
        end
    end

    initial begin
        word_t    sgn_a [10];
        word_t    sgn_b [10];
        word_t    dz_a [4];
        div_req_t r;
        void'($urandom(32'h127b));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        sgn_a = '{word_t'(100), word_t'(-100), word_t'(100), word_t'(-100), MIN_W,
                  MIN_W, '0, '0, MAX_W, '1};
        sgn_b = '{word_t'(7), word_t'(7), word_t'(-7), word_t'(-7), '1,
                  word_t'(1), word_t'(5), word_t'(-5), '1, MIN_W};
        dz_a  = '{word_t'(12345), word_t'(-9), MIN_W, '0};
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet after reset where the monitor flags any result.
        idle_cycles(8);

        // Unsigned requests one at a time with exact latency.
        for (int i = 0; i < 20; i++) begin
            send_req(rand_req(1'b0, 1'b0), 1'b1);
            wait_drain();
        end

        // Signed sign combinations, overflow and zero dividends.
        for (int i = 0; i < 10; i++) begin
            for (int w = 0; w < 2; w++) begin
                r.dividend  = sgn_a[i];
                r.divisor   = sgn_b[i];
                r.is_signed = 1'b1;
                r.want_rem  = 1'(w);
                r.tag       = '0;
                send_req(r, 1'b1);
                wait_drain();
            end
        end

        // Divisor zero.
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                r.dividend  = dz_a[i];
                r.divisor   = '0;
                r.is_signed = k[0];
                r.want_rem  = k[1];
                r.tag       = '0;
                send_req(r, 1'b1);
                wait_drain();
            end
        end

        // Back-to-back requests fill all lanes.
        saw_full = 1'b0;
        for (int i = 0; i < 16; i++) begin
            send_req(rand_req(1'b1, 1'b0), 1'b0);
        end
        wait_drain();
        if (!saw_full) begin
            n_errors++;
            $display("error at %0t: unit_ready never dropped with all lanes occupied", $time);
        end

        // Long random mix.
        for (int i = 0; i < 300; i++) begin
            send_req(rand_req(1'b1, 1'b1), 1'b0);
        end
        wait_drain();
        idle_cycles(10);

        $display("checks %0d, responses %0d of %0d, errors %0d",
            n_checks, n_returned, n_issued, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/div_unit_top.sv
`include "div_defs.svh"

module div_unit_top
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  div_req_t req,
    output logic     unit_ready,
    output logic     rsp_valid,
    output div_rsp_t rsp
);

    // Issue to cores.
    lane_mask_t lane_start;
    word_t      mag_dividend;
    word_t      mag_divisor;
    // Issue to writeback.
    lane_meta_t lane_meta [`DIV_LANES];
    // Cores to writeback.
    lane_mask_t lane_complete;
    lane_mask_t lane_div_zero;
    word_t      lane_quot [`DIV_LANES];
    word_t      lane_rem [`DIV_LANES];
    // Writeback back to cores and issue.
    lane_mask_t lane_ack;

    div_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .lane_ack     (lane_ack),
        .unit_ready   (unit_ready),
        .lane_start   (lane_start),
        .mag_dividend (mag_dividend),
        .mag_divisor  (mag_divisor),
        .lane_meta    (lane_meta)
    );

    // Cores share the operand bus, only the started one samples it.
    for (genvar g = 0; g < `DIV_LANES; g++) begin : g_lane
        div_radix2 #(
            .WIDTH (`DIV_WIDTH)
        ) u_core (
            .clk          (clk),
            .rst          (rst),
            .start        (lane_start[g]),
            .ack          (lane_ack[g]),
            .dividend     (mag_dividend),
            .divisor      (mag_divisor),
            .quotient     (lane_quot[g]),
            .remainder    (lane_rem[g]),
            .complete     (lane_complete[g]),
            .divisor_zero (lane_div_zero[g])
        );
    end

    div_writeback u_writeback (
        .clk           (clk),
        .rst           (rst),
        .lane_complete (lane_complete),
        .lane_div_zero (lane_div_zero),
        .lane_quot     (lane_quot),
        .lane_rem      (lane_rem),
        .lane_meta     (lane_meta),
        .lane_ack      (lane_ack),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

endmodule

// File: hw/div_writeback.sv
`include "div_defs.svh"

module div_writeback
    import div_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lane_mask_t lane_complete,
    input  lane_mask_t lane_div_zero,
    input  word_t      lane_quot [`DIV_LANES],
    input  word_t      lane_rem [`DIV_LANES],
    input  lane_meta_t lane_meta [`DIV_LANES],
    output lane_mask_t lane_ack,
    output logic       rsp_valid,
    output div_rsp_t   rsp
);

    // Round-robin pointer.
    // Points at the lane with highest priority this cycle.
    lane_idx_t  rr_ptr;
    lane_idx_t  cand;
    lane_idx_t  grant_idx;
    logic       grant_found;
    // Selected lane data.
    lane_meta_t sel_meta;
    word_t      raw_val;
    logic       neg_val;
    word_t      fixed_val;

    // Search from the pointer upward with wrap.
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        cand        = rr_ptr;
        for (int k = 0; k < `DIV_LANES; k++) begin
            cand = lane_idx_t'((int'(rr_ptr) + k) % `DIV_LANES);
            if (!grant_found && lane_complete[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // Ack goes back in the selection cycle.
    // The core drops complete at the next edge.
    always_comb begin
        lane_ack = '0;
        if (grant_found) begin
            lane_ack[grant_idx] = 1'b1;
        end
    end

    // Move past the granted lane so others get a turn.
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_found) begin
            if (grant_idx == lane_idx_t'(`DIV_LANES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= grant_idx + lane_idx_t'(1);
            end
        end
    end

    assign sel_meta = lane_meta[grant_idx];
    assign raw_val  = sel_meta.want_rem ? lane_rem[grant_idx] : lane_quot[grant_idx];
    assign neg_val  = sel_meta.want_rem ? sel_meta.rem_neg : sel_meta.quot_neg;

    // Result fixup.
    always_comb begin
        fixed_val = neg_val ? (~raw_val + word_t'(1)) : raw_val;
        // Divide by zero gives all ones for the quotient.
        // The core leaves the dividend magnitude in the remainder, so
        // the normal sign fixup rebuilds the original dividend.
        if (lane_div_zero[grant_idx] && !sel_meta.want_rem) begin
            fixed_val = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= grant_found;
        end
    end

    // Payload loads on a grant and holds otherwise.
    always_ff @(posedge clk) begin
        if (grant_found) begin
            rsp.result <= fixed_val;
            rsp.tag    <= sel_meta.tag;
        end
    end

    // A finished lane waits at most one turn of the pointer.
    for (genvar i = 0; i < `DIV_LANES; i++) begin : g_fair
        a_ack_fair : assert property (@(posedge clk) disable iff (rst)
            lane_complete[i] |-> ##[0:`DIV_LANES-1] lane_ack[i]);
    end

endmodule

// File: hw/div_issue.sv
`include "div_defs.svh"

module div_issue
    import div_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  div_req_t   req,
    input  lane_mask_t lane_ack,
    output logic       unit_ready,
    output lane_mask_t lane_start,
    output word_t      mag_dividend,
    output word_t      mag_divisor,
    output lane_meta_t lane_meta [`DIV_LANES]
);

    // Lane occupancy.
    // A lane stays busy from start until its result is acked.
    lane_mask_t busy;
    lane_mask_t free_mask;
    lane_idx_t  free_idx;
    // Operand signs, only meaningful for signed requests.
    logic       dividend_neg;
    logic       divisor_neg;
    lane_meta_t new_meta;

    assign free_mask  = ~busy;
    assign unit_ready = |free_mask;

    // Lowest-numbered free lane wins.
    always_comb begin
        free_idx = '0;
        for (int i = `DIV_LANES - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                free_idx = lane_idx_t'(i);
            end
        end
    end

    // Start strobe goes out in the same cycle as the request.
    always_comb begin
        lane_start = '0;
        if (req_valid) begin
            lane_start[free_idx] = 1'b1;
        end
    end

    assign dividend_neg = req.is_signed & req.dividend[`DIV_WIDTH-1];
    assign divisor_neg  = req.is_signed & req.divisor[`DIV_WIDTH-1];

    // Cores divide magnitudes only.
    // The most negative value maps onto itself, which is correct unsigned.
    assign mag_dividend = dividend_neg ? (~req.dividend + word_t'(1)) : req.dividend;
    assign mag_divisor  = divisor_neg ? (~req.divisor + word_t'(1)) : req.divisor;

    // Sign fixup rules for writeback.
    always_comb begin
        new_meta.tag      = req.tag;
        new_meta.want_rem = req.want_rem;
        new_meta.quot_neg = dividend_neg ^ divisor_neg;
        // Remainder takes the sign of the dividend.
        new_meta.rem_neg  = dividend_neg;
    end

    // Metadata is written with the start edge and stays put while busy.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            if (lane_start[i]) begin
                lane_meta[i] <= new_meta;
            end
        end
    end

    // Start sets and ack clears.
    // They never hit the same lane in one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy | lane_start) & ~lane_ack;
        end
    end

    // Requester must respect unit_ready.
    a_req_ready : assert property (@(posedge clk) disable iff (rst)
        req_valid |-> unit_ready);

    // Writeback only drains lanes that issue has started.
    a_ack_busy : assert property (@(posedge clk) disable iff (rst)
        (lane_ack & ~busy) == '0);

endmodule

// File: hw/div_radix2.sv
module div_radix2 #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             ack,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder,
    output logic             complete,
    output logic             divisor_zero
);

    // Partial remainder.
    logic [WIDTH-1:0] rem_q;
    // Dividend bits shift out at the top, quotient bits shift in at the bottom.
    logic [WIDTH-1:0] quot_q;
    // Divisor latched at start.
    logic [WIDTH-1:0] divisor_q;
    // One-hot iteration counter.
    logic [WIDTH-1:0] iter_cnt;
    // High while the core is idle or finished.
    logic             terminate;
    // Shifted remainder and trial subtraction.
    logic [WIDTH:0]   trial;
    logic [WIDTH:0]   diff;
    logic             sub_neg;

    // Bring down the next dividend bit.
    assign trial   = {rem_q, quot_q[WIDTH-1]};
    assign diff    = trial - {1'b0, divisor_q};
    // Borrow out means the divisor did not fit.
    assign sub_neg = diff[WIDTH];

    assign quotient  = quot_q;
    assign remainder = rem_q;

    // Datapath.
    // Restore by keeping the shifted value when the subtraction borrows.
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            quot_q    <= dividend;
            divisor_q <= divisor;
        end else if (!terminate) begin
            rem_q  <= sub_neg ? trial[WIDTH-1:0] : diff[WIDTH-1:0];
            quot_q <= {quot_q[WIDTH-2:0], ~sub_neg};
        end
    end

    // Full compare of the divisor, held for the whole operation.
    always_ff @(posedge clk) begin
        if (start) begin
            divisor_zero <= (divisor == '0);
        end
    end

    // Control.
    // The start bit walks through the counter, last bit ends the run.
    always_ff @(posedge clk) begin
        if (rst) begin
            iter_cnt  <= '0;
            terminate <= 1'b1;
            complete  <= 1'b0;
        end else begin
            iter_cnt <= {iter_cnt[WIDTH-2:0], start};
            if (start) begin
                terminate <= 1'b0;
            end else if (iter_cnt[WIDTH-1]) begin
                terminate <= 1'b1;
            end
            // Result is held until writeback takes it.
            if (iter_cnt[WIDTH-1]) begin
                complete <= 1'b1;
            end else if (ack) begin
                complete <= 1'b0;
            end
        end
    end

    // Issue may only start a core that is idle and already drained.
    a_start_idle : assert property (@(posedge clk) disable iff (rst)
        start |-> (terminate && !complete));

    // Writeback may only ack a finished core.
    a_ack_complete : assert property (@(posedge clk) disable iff (rst)
        ack |-> complete);

endmodule

// File: hw/div_pkg.sv
`include "div_defs.svh"

package div_pkg;

    // Operand or result word.
    typedef logic [`DIV_WIDTH-1:0] word_t;

    // Requester identifier, echoed back with the result.
    typedef logic [`DIV_TAG_W-1:0] tag_t;

    // Index of one divider core.
    typedef logic [`DIV_LANE_IDX_W-1:0] lane_idx_t;

    // One bit per divider core.
    typedef logic [`DIV_LANES-1:0] lane_mask_t;

    // Divide request as presented by the execute stage.
    typedef struct packed {
        word_t dividend;
        word_t divisor;
        logic  is_signed;
        logic  want_rem;
        tag_t  tag;
    } div_req_t;

    // Per-lane data that writeback needs to finish a result.
    // Sign flags are only set for signed operations.
    typedef struct packed {
        tag_t tag;
        logic want_rem;
        logic quot_neg;
        logic rem_neg;
    } lane_meta_t;

    // Final tagged result.
    typedef struct packed {
        word_t result;
        tag_t  tag;
    } div_rsp_t;

endpackage

// File: hw/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand and result width.
// Matches XLEN of the attached core.
`define DIV_WIDTH 32

// Number of divider cores working in parallel.
// One request can issue per cycle while a core is free.
`define DIV_LANES 4

// Width of the requester tag.
// Each in-flight request needs a unique tag.
`define DIV_TAG_W 4

// Derived width of a lane index.
// Used where a lane number is carried.
`define DIV_LANE_IDX_W $clog2(`DIV_LANES)

`endif
